//--- run_sim.sh
#!/bin/sh
# Build with Verilator, run, and judge the result from sim.log
rm -rf obj_dir sim.log
verilator --binary --timing --top-module debug_unit_tb -f sim.f -o debug_unit_sim > sim.log 2>&1 \
	&& ./obj_dir/debug_unit_sim >> sim.log 2>&1 \
	|| echo "Simulation finished: FAIL" >> sim.log
if grep -q "Simulation finished: FAIL" sim.log || ! grep -q "Simulation finished: PASS" sim.log; then
	echo "FAIL, see sim.log"
	exit 1
fi
echo "PASS"

//--- sim.f
+incdir+source
source/debug_pkg.sv
source/uart_rx.sv
source/uart_tx.sv
source/byte_fifo.sv
source/dump_sequencer.sv
source/debug_unit.sv
test/debug_unit_tb.sv

//--- source/byte_fifo.sv
`timescale 1ns/100ps
`default_nettype none

`include "debug_params.svh"

module byte_fifo
	import debug_pkg::*;
#(
	parameter int DEPTH = `FIFO_DEPTH
)
(
	input  wire   clk,
	input  wire   reset,
	input  byte_t fifo_din,
	input  wire   fifo_wr,
	input  wire   fifo_rd,
	output byte_t fifo_dout,
	output logic  fifo_full,
	output logic  fifo_empty
);

	localparam int PTR_W = $clog2(DEPTH);
	localparam int CNT_W = $clog2(DEPTH + 1);

	byte_t            mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             do_wr;
	logic             do_rd;

	assign do_wr = fifo_wr && !fifo_full;
	assign do_rd = fifo_rd && !fifo_empty;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (do_wr)
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			case ({do_wr, do_rd})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (do_wr)
			mem[wr_ptr] <= fifo_din;
	end

	// Fall-through read, head byte always on the output
	assign fifo_dout  = mem[rd_ptr];
	assign fifo_full  = (count == CNT_W'(DEPTH));
	assign fifo_empty = (count == '0);

endmodule

`default_nettype wire

//--- source/debug_params.svh
`ifndef DEBUG_PARAMS_SVH
`define DEBUG_PARAMS_SVH

////////////////////////////////////////////////////////////////////////////
// Serial line timing
////////////////////////////////////////////////////////////////////////////

// Clock cycles per serial bit, kept short for simulation
`define CLKS_PER_BIT 8

// Bytes buffered between the sequencer and the transmitter
`define FIFO_DEPTH 16

////////////////////////////////////////////////////////////////////////////
// Command bytes and dump lengths
////////////////////////////////////////////////////////////////////////////

// ASCII "A", step once and dump the core snapshot
`define CMD_STEP 8'h41
// ASCII "B", dump the start of data memory
`define CMD_MEM 8'h42

`define NUM_REGS 32
`define MEM_DUMP_WORDS 21

`endif

//--- source/debug_pkg.sv
`default_nettype none

package debug_pkg;

	// One serial data byte
	typedef logic [7:0] byte_t;

	// Processor word for PC, instruction, register and memory data
	typedef logic [31:0] word_t;

	// General register index
	typedef logic [4:0] reg_addr_t;

	// Word address on the memory debug port
	typedef logic [31:0] mem_addr_t;

	// Dump sequencer states
	typedef enum logic [2:0] {
		IDLE,
		STEP,
		SEND_CORE,
		SEND_MEM,
		DONE
	} seq_state_t;

endpackage

`default_nettype wire

//--- source/debug_unit.sv
`timescale 1ns/100ps
`default_nettype none

module debug_unit
	import debug_pkg::*;
(
	input  wire       clk,
	input  wire       reset,
	input  wire       rx,
	output logic      tx,
	input  word_t     pc,
	input  word_t     instruction,
	input  word_t     reg_data,
	input  word_t     mem_data,
	output logic      step,
	output logic      debug_mode,
	output reg_addr_t reg_addr,
	output mem_addr_t mem_addr
);

	byte_t rx_byte;
	logic  rx_valid;
	byte_t fifo_din;
	logic  fifo_wr;
	logic  fifo_rd;
	byte_t fifo_dout;
	logic  fifo_full;
	logic  fifo_empty;

	////////////////////////////////////////////////////////////////////////////
	// Receive, sequence, buffer, transmit
	////////////////////////////////////////////////////////////////////////////

	uart_rx uart_rx_i (
		.clk      (clk),
		.reset    (reset),
		.rx       (rx),
		.rx_byte  (rx_byte),
		.rx_valid (rx_valid)
	);

	dump_sequencer dump_sequencer_i (
		.clk         (clk),
		.reset       (reset),
		.rx_byte     (rx_byte),
		.rx_valid    (rx_valid),
		.pc          (pc),
		.instruction (instruction),
		.reg_data    (reg_data),
		.mem_data    (mem_data),
		.fifo_full   (fifo_full),
		.step        (step),
		.debug_mode  (debug_mode),
		.reg_addr    (reg_addr),
		.mem_addr    (mem_addr),
		.fifo_din    (fifo_din),
		.fifo_wr     (fifo_wr)
	);

	// Default depth from the shared constants
	byte_fifo byte_fifo_i (
		.clk        (clk),
		.reset      (reset),
		.fifo_din   (fifo_din),
		.fifo_wr    (fifo_wr),
		.fifo_rd    (fifo_rd),
		.fifo_dout  (fifo_dout),
		.fifo_full  (fifo_full),
		.fifo_empty (fifo_empty)
	);

	uart_tx uart_tx_i (
		.clk        (clk),
		.reset      (reset),
		.fifo_dout  (fifo_dout),
		.fifo_empty (fifo_empty),
		.fifo_rd    (fifo_rd),
		.tx         (tx)
	);

endmodule

`default_nettype wire

//--- source/dump_sequencer.sv
`timescale 1ns/100ps
`default_nettype none

`include "debug_params.svh"

module dump_sequencer
	import debug_pkg::*;
(
	input  wire       clk,
	input  wire       reset,
	input  byte_t     rx_byte,
	input  wire       rx_valid,
	input  word_t     pc,
	input  word_t     instruction,
	input  word_t     reg_data,
	input  word_t     mem_data,
	input  wire       fifo_full,
	output logic      step,
	output logic      debug_mode,
	output reg_addr_t reg_addr,
	output mem_addr_t mem_addr,
	output byte_t     fifo_din,
	output logic      fifo_wr
);

	// PC and instruction come before the register file
	localparam int CORE_BYTES = (`NUM_REGS + 2) * 4;
	localparam int MEM_BYTES  = `MEM_DUMP_WORDS * 4;

	seq_state_t state;
	seq_state_t next_state;
	logic [7:0] byte_idx;
	logic [5:0] word_idx;
	logic [1:0] lane;
	word_t      sel_word;
	logic       sending;
	logic       last_byte;

	////////////////////////////////////////////////////////////////////////////
	// Byte selection
	////////////////////////////////////////////////////////////////////////////

	assign word_idx = byte_idx[7:2];
	assign lane     = byte_idx[1:0];

	// Register and memory addresses follow the word index
	assign reg_addr = reg_addr_t'(word_idx - 6'd2);
	assign mem_addr = mem_addr_t'(word_idx);

	always_comb
	begin
		if (state == SEND_MEM)
			sel_word = mem_data;
		else if (word_idx == 6'd0)
			sel_word = pc;
		else if (word_idx == 6'd1)
			sel_word = instruction;
		else
			sel_word = reg_data;
	end

	// Least significant lane goes out first
	assign fifo_din = sel_word[{lane, 3'b000} +: 8];

	assign sending = (state == SEND_CORE) || (state == SEND_MEM);
	assign fifo_wr = sending && !fifo_full;

	assign last_byte = (state == SEND_MEM) ? (byte_idx == 8'(MEM_BYTES - 1))
		: (byte_idx == 8'(CORE_BYTES - 1));

	// Memory reads are combinational, so a level is enough
	assign debug_mode = (state == SEND_MEM);

	////////////////////////////////////////////////////////////////////////////
	// Command FSM
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		next_state = state;
		case (state)
			IDLE:
			begin
				// Commands are only heard here
				if (rx_valid && rx_byte == `CMD_STEP)
					next_state = STEP;
				else if (rx_valid && rx_byte == `CMD_MEM)
					next_state = SEND_MEM;
			end
			STEP:
				next_state = SEND_CORE;
			SEND_CORE, SEND_MEM:
			begin
				if (fifo_wr && last_byte)
					next_state = DONE;
			end
			DONE:
				next_state = IDLE;
			default:
				next_state = IDLE;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state    <= IDLE;
			byte_idx <= '0;
			step     <= 1'b0;
		end
		else
		begin
			state <= next_state;
			// One-cycle pulse following the STEP state
			step  <= (state == STEP);
			// Index only moves when the FIFO takes the byte
			if (fifo_wr)
				byte_idx <= last_byte ? '0 : byte_idx + 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- source/uart_rx.sv
`timescale 1ns/100ps
`default_nettype none

`include "debug_params.svh"

module uart_rx
	import debug_pkg::*;
(
	input  wire   clk,
	input  wire   reset,
	input  wire   rx,
	output byte_t rx_byte,
	output logic  rx_valid
);

	localparam int CNT_W = $clog2(`CLKS_PER_BIT);
	localparam logic [CNT_W-1:0] HALF_BIT = CNT_W'(`CLKS_PER_BIT / 2 - 1);
	localparam logic [CNT_W-1:0] FULL_BIT = CNT_W'(`CLKS_PER_BIT - 1);

	typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

	rx_state_t        state;
	logic             rx_meta;
	logic             rx_sync;
	logic [CNT_W-1:0] baud_cnt;
	logic [2:0]       bit_cnt;
	byte_t            shift;

	// Two-flop synchronizer, line idles high
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
		end
		else
		begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Frame timing
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state    <= RX_IDLE;
			baud_cnt <= '0;
			bit_cnt  <= '0;
			rx_valid <= 1'b0;
		end
		else
		begin
			rx_valid <= 1'b0;
			case (state)
				RX_IDLE:
				begin
					baud_cnt <= '0;
					if (!rx_sync)
						state <= RX_START;
				end
				RX_START:
				begin
					// Recheck the start bit halfway through
					if (baud_cnt == HALF_BIT)
					begin
						baud_cnt <= '0;
						bit_cnt  <= '0;
						state    <= rx_sync ? RX_IDLE : RX_DATA;
					end
					else
						baud_cnt <= baud_cnt + 1'b1;
				end
				RX_DATA:
				begin
					if (baud_cnt == FULL_BIT)
					begin
						baud_cnt <= '0;
						bit_cnt  <= bit_cnt + 1'b1;
						if (bit_cnt == 3'd7)
							state <= RX_STOP;
					end
					else
						baud_cnt <= baud_cnt + 1'b1;
				end
				RX_STOP:
				begin
					if (baud_cnt == FULL_BIT)
					begin
						// Low stop bit means a framing error, byte dropped
						rx_valid <= rx_sync;
						baud_cnt <= '0;
						state    <= RX_IDLE;
					end
					else
						baud_cnt <= baud_cnt + 1'b1;
				end
				default:
					state <= RX_IDLE;
			endcase
		end
	end

	// LSB arrives first
	always_ff @(posedge clk)
	begin
		if (state == RX_DATA && baud_cnt == FULL_BIT)
			shift <= {rx_sync, shift[7:1]};
	end

	assign rx_byte = shift;

endmodule

`default_nettype wire

//--- source/uart_tx.sv
`timescale 1ns/100ps
`default_nettype none

`include "debug_params.svh"

module uart_tx
	import debug_pkg::*;
(
	input  wire   clk,
	input  wire   reset,
	input  byte_t fifo_dout,
	input  wire   fifo_empty,
	output logic  fifo_rd,
	output logic  tx
);

	localparam int CNT_W = $clog2(`CLKS_PER_BIT);
	localparam logic [CNT_W-1:0] FULL_BIT = CNT_W'(`CLKS_PER_BIT - 1);

	typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_t;

	tx_state_t        state;
	logic [CNT_W-1:0] baud_cnt;
	logic [2:0]       bit_cnt;
	byte_t            shift;
	logic             bit_end;
	logic             load;

	assign bit_end = (baud_cnt == FULL_BIT);

	// Next byte taken when idle or straight after a stop bit
	assign load = !fifo_empty && (state == TX_IDLE || (state == TX_STOP && bit_end));

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state    <= TX_IDLE;
			baud_cnt <= '0;
			bit_cnt  <= '0;
			fifo_rd  <= 1'b0;
		end
		else
		begin
			fifo_rd <= load;
			if (load)
			begin
				state    <= TX_START;
				baud_cnt <= '0;
			end
			else
			begin
				case (state)
					TX_IDLE:
						baud_cnt <= '0;
					TX_START:
					begin
						baud_cnt <= bit_end ? '0 : baud_cnt + 1'b1;
						if (bit_end)
						begin
							bit_cnt <= '0;
							state   <= TX_DATA;
						end
					end
					TX_DATA:
					begin
						baud_cnt <= bit_end ? '0 : baud_cnt + 1'b1;
						if (bit_end)
						begin
							bit_cnt <= bit_cnt + 1'b1;
							if (bit_cnt == 3'd7)
								state <= TX_STOP;
						end
					end
					TX_STOP:
					begin
						baud_cnt <= bit_end ? '0 : baud_cnt + 1'b1;
						if (bit_end)
							state <= TX_IDLE;
					end
					default:
						state <= TX_IDLE;
				endcase
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (load)
			shift <= fifo_dout;
		else if (state == TX_DATA && bit_end)
			shift <= shift >> 1;
	end

	// Line held high outside start and data bits
	assign tx = (state == TX_START) ? 1'b0 : (state == TX_DATA) ? shift[0] : 1'b1;

endmodule

`default_nettype wire

//--- test/debug_unit_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "debug_params.svh"

module debug_unit_tb
	import debug_pkg::*;
();

	localparam int BIT_CLKS     = `CLKS_PER_BIT;
	localparam int TIMEOUT_CLKS = 40 * `CLKS_PER_BIT;

	logic      clk;
	logic      reset;
	logic      rx;
	logic      tx;
	word_t     pc;
	word_t     instruction;
	word_t     reg_data;
	word_t     mem_data;
	logic      step;
	logic      debug_mode;
	reg_addr_t reg_addr;
	mem_addr_t mem_addr;

	// Processor state model
	word_t     regs [`NUM_REGS];
	word_t     mem_model [`MEM_DUMP_WORDS];
	integer    seed;

	int        step_pulses = 0;
	int        step_cycles = 0;
	int        debug_cycles = 0;
	logic      step_prev = 1'b0;

	debug_unit debug_unit_i (
		.clk         (clk),
		.reset       (reset),
		.rx          (rx),
		.tx          (tx),
		.pc          (pc),
		.instruction (instruction),
		.reg_data    (reg_data),
		.mem_data    (mem_data),
		.step        (step),
		.debug_mode  (debug_mode),
		.reg_addr    (reg_addr),
		.mem_addr    (mem_addr)
	);

	// Register file and memory answer combinationally
	assign reg_data = regs[reg_addr];
	assign mem_data = (mem_addr < 32'(`MEM_DUMP_WORDS)) ? mem_model[mem_addr[4:0]] : '0;

	initial
		clk = 1'b0;

	always #20 clk = ~clk;

	// Counts step pulses, step high cycles and debug_mode cycles
	always @(negedge clk)
	begin
		if (!reset)
		begin
			if (step)
				step_cycles++;
			if (step && !step_prev)
				step_pulses++;
			if (debug_mode)
				debug_cycles++;
			step_prev = step;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Reporting
	////////////////////////////////////////////////////////////////////////////

	task automatic stop_with_failure();
		$display("Simulation finished: FAIL");
		$fatal(1, "Run stopped at the first error");
	endtask

	task automatic check_value(input string what, input logic [31:0] got,
		input logic [31:0] expected);
		if (got !== expected)
		begin
			$display("[ERROR] %0d ns: %s is %h, expected %h", $time, what, got,
				expected);
			stop_with_failure();
		end
	endtask

	function automatic byte_t word_byte(input word_t w, input int lane);
		return byte_t'(w >> (8 * lane));
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Serial line tasks
	////////////////////////////////////////////////////////////////////////////

	// Called on a falling edge and returns after the stop bit
	task automatic send_byte(input byte_t data);
		int i;
		rx = 1'b0;
		repeat (BIT_CLKS) @(negedge clk);
		for (i = 0; i < 8; i++)
		begin
			rx = data[i];
			repeat (BIT_CLKS) @(negedge clk);
		end
		rx = 1'b1;
		repeat (BIT_CLKS) @(negedge clk);
	endtask

	task automatic receive_byte(output byte_t data);
		int waited;
		int i;
		waited = 0;
		@(negedge clk);
		while (tx !== 1'b0)
		begin
			if (waited == TIMEOUT_CLKS)
			begin
				$display("Timed out waiting for a start bit on tx");
				stop_with_failure();
			end
			waited++;
			@(negedge clk);
		end
		// Start seen half a cycle in so step on to mid bit
		repeat (BIT_CLKS / 2 - 1) @(negedge clk);
		check_value("start bit", 32'(tx), 32'h0);
		for (i = 0; i < 8; i++)
		begin
			repeat (BIT_CLKS) @(negedge clk);
			data[i] = tx;
		end
		repeat (BIT_CLKS) @(negedge clk);
		check_value("stop bit", 32'(tx), 32'h1);
	endtask

	task automatic expect_word(input string what, input word_t w);
		byte_t got;
		int lane;
		for (lane = 0; lane < 4; lane++)
		begin
			receive_byte(got);
			check_value($sformatf("%s byte %0d", what, lane), 32'(got),
				32'(word_byte(w, lane)));
		end
	endtask

	task automatic wait_tx_idle();
		int quiet;
		int waited;
		quiet = 0;
		waited = 0;
		while (quiet < 2 * BIT_CLKS)
		begin
			if (waited == TIMEOUT_CLKS)
			begin
				$display("Timed out waiting for tx to go idle after a dump");
				stop_with_failure();
			end
			@(negedge clk);
			waited++;
			quiet = (tx === 1'b1) ? quiet + 1 : 0;
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Command scenarios
	////////////////////////////////////////////////////////////////////////////

	task automatic randomize_state();
		int i;
		pc = $random(seed);
		instruction = $random(seed);
		for (i = 0; i < `NUM_REGS; i++)
			regs[i] = $random(seed);
		for (i = 0; i < `MEM_DUMP_WORDS; i++)
			mem_model[i] = $random(seed);
	endtask

	task automatic run_step_dump();
		int r;
		int pulses_before;
		int cycles_before;
		int debug_before;
		pulses_before = step_pulses;
		cycles_before = step_cycles;
		debug_before = debug_cycles;
		send_byte(`CMD_STEP);
		expect_word("pc", pc);
		expect_word("instruction", instruction);
		for (r = 0; r < `NUM_REGS; r++)
			expect_word($sformatf("register %0d", r), regs[r]);
		wait_tx_idle();
		check_value("step pulses", 32'(step_pulses - pulses_before), 32'd1);
		check_value("step high cycles", 32'(step_cycles - cycles_before), 32'd1);
		check_value("debug_mode cycles in step dump",
			32'(debug_cycles - debug_before), 32'd0);
	endtask

	task automatic run_mem_dump();
		int w;
		int pulses_before;
		pulses_before = step_pulses;
		send_byte(`CMD_MEM);
		for (w = 0; w < `MEM_DUMP_WORDS; w++)
		begin
			expect_word($sformatf("memory word %0d", w), mem_model[w]);
			// Sequencer is still queueing while the first word goes out
			if (w == 0)
				check_value("debug_mode during memory dump", 32'(debug_mode), 32'h1);
		end
		wait_tx_idle();
		check_value("debug_mode after memory dump", 32'(debug_mode), 32'h0);
		check_value("step pulses in memory dump", 32'(step_pulses - pulses_before), 32'd0);
	endtask

	task automatic run_ignored_byte();
		byte_t cmd;
		int pulses_before;
		cmd = byte_t'($random(seed));
		while (cmd == `CMD_STEP || cmd == `CMD_MEM)
			cmd = byte_t'($random(seed));
		pulses_before = step_pulses;
		send_byte(cmd);
		repeat (40 * BIT_CLKS)
		begin
			@(negedge clk);
			check_value("tx after ignored byte", 32'(tx), 32'h1);
			check_value("debug_mode after ignored byte", 32'(debug_mode), 32'h0);
		end
		check_value("step pulses after ignored byte", 32'(step_pulses - pulses_before), 32'd0);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////////////////////

	initial
	begin
		int n;
		seed = 32'h6ee0_850a;
		reset = 1'b1;
		rx = 1'b1;
		randomize_state();
		repeat (4) @(negedge clk);
		reset = 1'b0;

		// Quiet line after reset
		repeat (20 * BIT_CLKS)
		begin
			@(negedge clk);
			check_value("tx after reset", 32'(tx), 32'h1);
			check_value("step after reset", 32'(step), 32'h0);
			check_value("debug_mode after reset", 32'(debug_mode), 32'h0);
		end

		randomize_state();
		run_step_dump();
		randomize_state();
		run_mem_dump();
		run_ignored_byte();

		// Random command mix with FIFO back-pressure on every dump
		for (n = 0; n < 10; n++)
		begin
			randomize_state();
			if (($random(seed) & 1) != 0)
				run_step_dump();
			else
				run_mem_dump();
		end

		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

`default_nettype wire
